// ==== build.f ====
common/core_cfg_pkg.sv
common/core_types_pkg.sv
src/misc_regs.sv
src/activity_leds.sv
vita_time/time_regs.sv
vita_time/vita_timer.sv
src/radio_ctrl_top.sv
tb/radio_ctrl_chk.sv
tb/tb_radio_ctrl.sv

// ==== common/core_cfg_pkg.sv ====
//////////////////////////////
// Settings map of the radio control plane
// Offsets are relative to the block base given to each module
//////////////////////////////
`default_nettype none

package core_cfg_pkg;

   //////////////////////////////
   // Block base addresses
   localparam int unsigned SR_MISC   = 0;    // 7 regs
   localparam int unsigned SR_TIME64 = 10;   // 3 regs
   localparam int unsigned SR_DIVSW  = 180;  // 2 regs

   //////////////////////////////
   // Misc register offsets
   localparam int unsigned OFS_CLK     = 0;
   localparam int unsigned OFS_SER     = 1;
   localparam int unsigned OFS_ADC     = 2;
   localparam int unsigned OFS_LED_SW  = 3;
   localparam int unsigned OFS_PHY     = 4;
   localparam int unsigned OFS_LED_SRC = 6;

   // Time register offsets
   localparam int unsigned OFS_TIME_HI  = 0;
   localparam int unsigned OFS_TIME_LO  = 1;
   localparam int unsigned OFS_TIME_IMM = 2;

   //////////////////////////////
   // Reset values and counts

   // 1 = LED bit from hardware, 0 = from software
   localparam logic [7:0] LED_SRC_RESET = 8'b0001_1110;

   localparam logic DIVSW_RESET = 1'b1;  // Both switches start high

   // PPS synchronizer depth
   localparam int unsigned PPS_SYNC_STAGES = 2;

endpackage

`default_nettype wire

// ==== common/core_types_pkg.sv ====
//////////////////////////////
// Types shared by the control plane
// Settings bus carries one write per strobe, no handshake
//////////////////////////////
`default_nettype none

package core_types_pkg;

   typedef logic [7:0]  set_addr_t;   // Settings address
   typedef logic [31:0] set_data_t;   // Settings data
   typedef logic [7:0]  ctrl_byte_t;  // 8 bit control register
   typedef logic [63:0] vita_time_t;  // Time in clock ticks

   // One settings write
   typedef struct packed {
      logic      stb;
      set_addr_t addr;
      set_data_t data;
   } set_bus_t;

   //////////////////////////////
   // Board control lines
   typedef struct packed {
      ctrl_byte_t clk_ctrl;   // Clock enables and selects
      ctrl_byte_t serdes;     // SERDES enable, PRBS, loopback, rx enable
      ctrl_byte_t adc;        // ADC on and output enable
      logic       phy_reset;  // Active high, board inverts it
      logic       divsw1;
      logic       divsw2;
   } board_ctrl_t;

   // Load request toward the time counter
   typedef struct packed {
      logic       load_now;
      logic       load_at_pps;
      vita_time_t new_time;
   } time_load_t;

endpackage

`default_nettype wire

// ==== src/activity_leds.sv ====
//////////////////////////////
// Front panel LEDs, hardware or software per bit
// Receive run shows one cycle late
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module activity_leds
   import core_types_pkg::*;
(
   input  wire        dsp_clk,
   input  wire        por_rst,
   input  ctrl_byte_t led_sw_i,
   input  ctrl_byte_t led_src_i,
   input  wire        run_rx0_i,
   input  wire        run_rx1_i,
   input  wire        run_tx_i,
   input  wire        clk_status_i,
   input  wire        link_good_i,
   output ctrl_byte_t leds_o
);

   logic       run_rx0_d1;
   logic       run_rx1_d1;
   ctrl_byte_t led_hw;

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         run_rx0_d1 <= 1'b0;
         run_rx1_d1 <= 1'b0;
      end else begin
         run_rx0_d1 <= run_rx0_i;
         run_rx1_d1 <= run_rx1_i;
      end
   end

   // Hardware pattern, bit 0 and top bits unused
   assign led_hw = {3'b000, run_tx_i, run_rx0_d1 | run_rx1_d1,
                    clk_status_i, link_good_i, 1'b0};

   assign leds_o = (led_src_i & led_hw) | (~led_src_i & led_sw_i);

endmodule

`default_nettype wire

// ==== src/misc_regs.sv ====
//////////////////////////////
// Misc control registers on the settings bus
// Writes show on the outputs one cycle after the strobe edge
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module misc_regs
   import core_cfg_pkg::*, core_types_pkg::*;
#(
   parameter int unsigned BASE_MISC  = SR_MISC,
   parameter int unsigned BASE_DIVSW = SR_DIVSW
) (
   input  wire         dsp_clk,
   input  wire         por_rst,
   input  set_bus_t    set_bus_i,
   output board_ctrl_t board_ctrl_o,
   output ctrl_byte_t  led_sw_o,
   output ctrl_byte_t  led_src_o
);

   //////////////////////////////
   // Register addresses
   localparam set_addr_t A_CLK     = set_addr_t'(BASE_MISC + OFS_CLK);
   localparam set_addr_t A_SER     = set_addr_t'(BASE_MISC + OFS_SER);
   localparam set_addr_t A_ADC     = set_addr_t'(BASE_MISC + OFS_ADC);
   localparam set_addr_t A_LED_SW  = set_addr_t'(BASE_MISC + OFS_LED_SW);
   localparam set_addr_t A_PHY     = set_addr_t'(BASE_MISC + OFS_PHY);
   localparam set_addr_t A_LED_SRC = set_addr_t'(BASE_MISC + OFS_LED_SRC);
   localparam set_addr_t A_DIVSW1  = set_addr_t'(BASE_DIVSW);
   localparam set_addr_t A_DIVSW2  = set_addr_t'(BASE_DIVSW + 1);

   board_ctrl_t board_q;
   ctrl_byte_t  led_sw_q;
   ctrl_byte_t  led_src_q;

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         board_q.clk_ctrl  <= '0;
         board_q.serdes    <= '0;
         board_q.adc       <= '0;
         board_q.phy_reset <= 1'b0;
         board_q.divsw1    <= DIVSW_RESET;
         board_q.divsw2    <= DIVSW_RESET;
         led_sw_q          <= '0;
         led_src_q         <= LED_SRC_RESET;
      end else if (set_bus_i.stb) begin
         case (set_bus_i.addr)
            A_CLK:     board_q.clk_ctrl  <= set_bus_i.data[7:0];
            A_SER:     board_q.serdes    <= set_bus_i.data[7:0];
            A_ADC:     board_q.adc       <= set_bus_i.data[7:0];
            A_LED_SW:  led_sw_q          <= set_bus_i.data[7:0];
            A_PHY:     board_q.phy_reset <= set_bus_i.data[0];
            A_LED_SRC: led_src_q         <= set_bus_i.data[7:0];
            A_DIVSW1:  board_q.divsw1    <= set_bus_i.data[0];
            A_DIVSW2:  board_q.divsw2    <= set_bus_i.data[0];
            default:   ;  // Other blocks' addresses
         endcase
      end
   end

   assign board_ctrl_o = board_q;
   assign led_sw_o     = led_sw_q;
   assign led_src_o    = led_src_q;

endmodule

`default_nettype wire

// ==== src/radio_ctrl_top.sv ====
//////////////////////////////
// Control plane top, all in dsp_clk
// Settings writes come straight from the port
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module radio_ctrl_top
   import core_cfg_pkg::*, core_types_pkg::*;
#(
   parameter int unsigned BASE_MISC  = SR_MISC,
   parameter int unsigned BASE_TIME  = SR_TIME64,
   parameter int unsigned BASE_DIVSW = SR_DIVSW
) (
   input  wire         dsp_clk,
   input  wire         por_rst,
   input  set_bus_t    set_bus_i,
   input  wire         pps_i,
   input  wire         run_rx0_i,
   input  wire         run_rx1_i,
   input  wire         run_tx_i,
   input  wire         clk_status_i,
   input  wire         serdes_link_up_i,
   output board_ctrl_t board_ctrl_o,
   output ctrl_byte_t  leds_o,
   output vita_time_t  vita_time_o,
   output vita_time_t  vita_time_pps_o,
   output logic        good_sync_o
);

   ctrl_byte_t led_sw;
   ctrl_byte_t led_src;
   time_load_t time_load;

   //////////////////////////////
   // Board control and LEDs
   misc_regs #(.BASE_MISC(BASE_MISC), .BASE_DIVSW(BASE_DIVSW)) misc_regs_i (
      .dsp_clk, .por_rst, .set_bus_i, .board_ctrl_o,
      .led_sw_o(led_sw), .led_src_o(led_src)
   );

   activity_leds activity_leds_i (
      .dsp_clk, .por_rst,
      .led_sw_i(led_sw), .led_src_i(led_src),
      .run_rx0_i, .run_rx1_i, .run_tx_i, .clk_status_i,
      .link_good_i(serdes_link_up_i & good_sync_o),  // Link LED needs time sync too
      .leds_o
   );

   //////////////////////////////
   // VITA time
   time_regs #(.BASE(BASE_TIME)) time_regs_i (
      .dsp_clk, .por_rst, .set_bus_i, .time_load_o(time_load)
   );

   vita_timer vita_timer_i (
      .dsp_clk, .por_rst, .pps_i, .time_load_i(time_load),
      .vita_time_o, .vita_time_pps_o, .good_sync_o
   );

endmodule

`default_nettype wire

// ==== tb/radio_ctrl_chk.sv ====
//////////////////////////////
// Assertions on time counting, sync flag and LED source reset
// Bound into the top, sees the wires between the blocks
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module radio_ctrl_chk
   import core_cfg_pkg::*, core_types_pkg::*;
(
   input wire             dsp_clk,
   input wire             por_rst,
   input wire vita_time_t vita_time_i,
   input wire             load_now_i,
   input wire             good_sync_i,
   input wire ctrl_byte_t led_src_i
);

   int unsigned fails = 0;  // Failed assertion count

   // Free running unless a load hit on the last edge
   time_step: assert property (@(posedge dsp_clk) disable iff (por_rst)
      !$past(por_rst) && !$past(load_now_i) && $stable(good_sync_i)
      |-> vita_time_i == $past(vita_time_i) + 64'd1)
      else begin
         $error("VITA time did not advance by exactly one tick");
         fails++;
      end

   sync_sticky: assert property (@(posedge dsp_clk) disable iff (por_rst)
      !$past(por_rst) && $past(good_sync_i) |-> good_sync_i)
      else begin
         $error("good_sync fell without a reset");
         fails++;
      end

   led_src_reset: assert property (@(posedge dsp_clk)
      $fell(por_rst) |-> led_src_i == LED_SRC_RESET)
      else begin
         $error("LED source register lost its reset value");
         fails++;
      end

endmodule

bind radio_ctrl_top radio_ctrl_chk radio_ctrl_chk_i (
   .dsp_clk, .por_rst,
   .vita_time_i(vita_time_o),
   .load_now_i(time_load.load_now),
   .good_sync_i(good_sync_o),
   .led_src_i(led_src)
);

`default_nettype wire

// ==== tb/tb_radio_ctrl.sv ====
//////////////////////////////
// Self checking testbench, model compared on every falling edge
// PPS pulses at least 4 cycles apart, PPS load staged 3+ cycles before
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_radio_ctrl
   import core_cfg_pkg::*, core_types_pkg::*;
();

   localparam int unsigned TEST_CYCLES = 350;
   localparam int unsigned CYCLE_LIMIT = 2 * TEST_CYCLES;
   localparam int unsigned PPS_GAP     = 37;  // Cycles between capture pulses

   logic        dsp_clk;
   logic        por_rst;
   logic        pps;
   logic        run_rx0, run_rx1, run_tx, clk_status, link_up;
   set_bus_t    set_bus;
   board_ctrl_t board_ctrl;
   ctrl_byte_t  leds;
   vita_time_t  vita_time, vita_time_pps;
   logic        good_sync;

   // Model state
   board_ctrl_t m_board;
   ctrl_byte_t  m_sw, m_src;
   logic        m_rx_d, m_sync, m_imm, m_pend, pps_last;
   set_data_t   m_hi;
   vita_time_t  m_time, m_pps_time, m_new, cap0;
   int unsigned ld_cnt, pps_cnt;
   int unsigned cycles = 0;
   int unsigned errors = 0;
   logic [31:0] rng;

   radio_ctrl_top dut_i (
      .dsp_clk, .por_rst, .set_bus_i(set_bus), .pps_i(pps),
      .run_rx0_i(run_rx0), .run_rx1_i(run_rx1), .run_tx_i(run_tx),
      .clk_status_i(clk_status), .serdes_link_up_i(link_up),
      .board_ctrl_o(board_ctrl), .leds_o(leds), .vita_time_o(vita_time),
      .vita_time_pps_o(vita_time_pps), .good_sync_o(good_sync)
   );

   initial begin
      dsp_clk = 1'b0;
      forever #10 dsp_clk = ~dsp_clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      return x ^ (x << 5);
   endfunction

   // Per bit choice, 1 in src = hardware pattern
   function automatic ctrl_byte_t ref_leds(input ctrl_byte_t sw, input ctrl_byte_t src,
                                           input logic rx_d, input logic tx,
                                           input logic clk_ok, input logic link);
      ctrl_byte_t hw;
      hw = {3'b000, tx, rx_d, clk_ok, link, 1'b0};
      return (src & hw) | (~src & sw);
   endfunction

   function automatic vita_time_t ref_time(input vita_time_t cur, input logic load,
                                           input vita_time_t value);
      return load ? value : cur + 64'd1;
   endfunction

   task automatic check_value(input string what, input logic [63:0] got,
                              input logic [63:0] expected);
      if (got !== expected) begin
         $display("ERROR %0t: %s got %h expected %h", $time, what, got, expected);
         errors++;
      end
   endtask

   task automatic wait_cycles(input int unsigned n);
      repeat (n) @(posedge dsp_clk);
      #2;
   endtask

   task automatic write_setting(input int unsigned addr, input set_data_t value);
      wait_cycles(1);
      set_bus = '{stb: 1'b1, addr: set_addr_t'(addr), data: value};
      wait_cycles(1);
      set_bus.stb = 1'b0;
   endtask

   task automatic pulse_pps();
      wait_cycles(1);
      pps = 1'b1;
      wait_cycles(3);
      pps = 1'b0;
   endtask

   // Misc and unmapped writes with random LED inputs
   task automatic random_misc_cycles(input int unsigned n);
      repeat (n) begin
         wait_cycles(1);
         rng = xorshift32(rng);
         {run_rx0, run_rx1, run_tx, clk_status, link_up} = rng[4:0];
         set_bus.stb  = rng[5];
         set_bus.addr = rng[9] ? set_addr_t'(SR_DIVSW + rng[7:6]) : set_addr_t'(rng[8:6]);
         rng = xorshift32(rng);
         set_bus.data = rng;
      end
      set_bus.stb = 1'b0;
   endtask

   //////////////////////////////
   // Reference model
   always @(posedge dsp_clk) begin
      if (por_rst) begin
         m_board <= '{8'h00, 8'h00, 8'h00, 1'b0, 1'b1, 1'b1};  // Switches start high
         m_sw    <= '0;
         m_src   <= LED_SRC_RESET;
         {m_rx_d, m_sync, m_imm, m_pend, pps_last} <= '0;
         {m_time, m_pps_time} <= '0;
         ld_cnt  <= 0;
         pps_cnt <= 0;
      end else begin
         m_rx_d   <= run_rx0 | run_rx1;
         pps_last <= pps;
         m_time   <= ref_time(m_time, ld_cnt == 1 || (pps_cnt == 1 && m_pend), m_new);
         if (ld_cnt != 0)
            ld_cnt <= ld_cnt - 1;
         if (pps && !pps_last)
            pps_cnt <= 2;  // Edge lands 3 cycles after the rise
         else if (pps_cnt != 0)
            pps_cnt <= pps_cnt - 1;
         if (pps_cnt == 1) begin
            m_pps_time <= m_time;
            m_sync     <= m_sync | m_pend;
            m_pend     <= 1'b0;
         end
         if (set_bus.stb) begin
            case (set_bus.addr)
               SR_MISC + OFS_CLK:        m_board.clk_ctrl  <= set_bus.data[7:0];
               SR_MISC + OFS_SER:        m_board.serdes    <= set_bus.data[7:0];
               SR_MISC + OFS_ADC:        m_board.adc       <= set_bus.data[7:0];
               SR_MISC + OFS_LED_SW:     m_sw              <= set_bus.data[7:0];
               SR_MISC + OFS_PHY:        m_board.phy_reset <= set_bus.data[0];
               SR_MISC + OFS_LED_SRC:    m_src             <= set_bus.data[7:0];
               SR_DIVSW:                 m_board.divsw1    <= set_bus.data[0];
               SR_DIVSW + 1:             m_board.divsw2    <= set_bus.data[0];
               SR_TIME64 + OFS_TIME_HI:  m_hi              <= set_bus.data;
               SR_TIME64 + OFS_TIME_IMM: m_imm             <= set_bus.data[0];
               SR_TIME64 + OFS_TIME_LO: begin
                  m_new <= {m_hi, set_bus.data};
                  if (m_imm)
                     ld_cnt <= 2;
                  else
                     m_pend <= 1'b1;
               end
               default: ;
            endcase
         end
      end
   end

   // Compare with the model
   always @(negedge dsp_clk) begin
      if (!por_rst) begin
         check_value("board_ctrl", 64'(board_ctrl), 64'(m_board));
         check_value("leds", 64'(leds),
                     64'(ref_leds(m_sw, m_src, m_rx_d, run_tx, clk_status, link_up & m_sync)));
         check_value("vita_time", vita_time, m_time);
         check_value("vita_time_pps", vita_time_pps, m_pps_time);
         check_value("good_sync", 64'(good_sync), 64'(m_sync));
      end
   end

   always @(posedge dsp_clk) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("STATUS: FAIL");
         $finish;
      end
   end

   //////////////////////////////
   // Stimulus
   initial begin
      por_rst = 1'b1;
      pps     = 1'b0;
      set_bus = '0;
      rng     = 32'd99158;
      {run_rx0, run_rx1, run_tx, clk_status, link_up} = '0;
      wait_cycles(10);
      por_rst = 1'b0;

      // Random misc writes, unmapped addresses, LED inputs
      random_misc_cycles(200);

      // Immediate load
      write_setting(SR_TIME64 + OFS_TIME_IMM, 32'd1);
      write_setting(SR_TIME64 + OFS_TIME_HI, xorshift32(rng));
      write_setting(SR_TIME64 + OFS_TIME_LO, rng);
      wait_cycles(20);

      // Load at PPS
      write_setting(SR_TIME64 + OFS_TIME_IMM, 32'd0);
      write_setting(SR_TIME64 + OFS_TIME_HI, 32'h0000_0001);
      write_setting(SR_TIME64 + OFS_TIME_LO, 32'h8000_0000);
      wait_cycles(5);
      pulse_pps();
      wait_cycles(10);
      check_value("good_sync after PPS load", 64'(good_sync), 64'd1);

      // Link LED follows the link input only once time is synced
      random_misc_cycles(40);

      // Two captures PPS_GAP cycles apart
      pulse_pps();
      cap0 = vita_time_pps;
      wait_cycles(PPS_GAP - 4);
      pulse_pps();
      check_value("PPS capture spacing", vita_time_pps - cap0, 64'(PPS_GAP));
      wait_cycles(5);

      errors += dut_i.radio_ctrl_chk_i.fails;
      $display("Run finished with %0d errors", errors);
      if (errors == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// ==== vita_time/time_regs.sv ====
//////////////////////////////
// Staging for a new time value
// Write HI first, LO write issues the load request
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module time_regs
   import core_cfg_pkg::*, core_types_pkg::*;
#(
   parameter int unsigned BASE = SR_TIME64
) (
   input  wire        dsp_clk,
   input  wire        por_rst,
   input  set_bus_t   set_bus_i,
   output time_load_t time_load_o
);

   localparam set_addr_t A_HI  = set_addr_t'(BASE + OFS_TIME_HI);
   localparam set_addr_t A_LO  = set_addr_t'(BASE + OFS_TIME_LO);
   localparam set_addr_t A_IMM = set_addr_t'(BASE + OFS_TIME_IMM);

   set_data_t time_hi;
   set_data_t time_lo;
   logic      imm_mode;    // 1 = load now, 0 = at next PPS
   logic      lo_written;  // LO stored on the last edge
   logic      load_now;
   logic      load_at_pps;

   //////////////////////////////
   // Time words, payload only
   always_ff @(posedge dsp_clk) begin
      if (set_bus_i.stb && set_bus_i.addr == A_HI)
         time_hi <= set_bus_i.data;
      if (set_bus_i.stb && set_bus_i.addr == A_LO)
         time_lo <= set_bus_i.data;
   end

   //////////////////////////////
   // Mode and request pulse
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         imm_mode    <= 1'b0;
         lo_written  <= 1'b0;
         load_now    <= 1'b0;
         load_at_pps <= 1'b0;
      end else begin
         if (set_bus_i.stb && set_bus_i.addr == A_IMM)
            imm_mode <= set_bus_i.data[0];
         lo_written  <= set_bus_i.stb && (set_bus_i.addr == A_LO);
         load_now    <= lo_written & imm_mode;   // One cycle wide
         load_at_pps <= lo_written & ~imm_mode;
      end
   end

   assign time_load_o = '{load_now:    load_now,
                          load_at_pps: load_at_pps,
                          new_time:    {time_hi, time_lo}};

endmodule

`default_nettype wire

// ==== vita_time/vita_timer.sv ====
//////////////////////////////
// 64 bit VITA time, one tick per dsp_clk
// PPS is async, edge seen 3 cycles after it rises
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module vita_timer
   import core_cfg_pkg::*, core_types_pkg::*;
(
   input  wire        dsp_clk,
   input  wire        por_rst,
   input  wire        pps_i,
   input  time_load_t time_load_i,
   output vita_time_t vita_time_o,
   output vita_time_t vita_time_pps_o,
   output logic       good_sync_o
);

   // Sync stages plus one more flop for the edge
   logic [PPS_SYNC_STAGES:0] pps_sr;
   logic                     pps_edge;
   logic                     pend_valid;   // PPS mode load armed
   vita_time_t               pend_time;
   logic                     pps_load;
   vita_time_t               time_q;
   vita_time_t               time_pps_q;

   //////////////////////////////
   // PPS synchronizer and edge detect
   always_ff @(posedge dsp_clk) begin
      if (por_rst)
         pps_sr <= '0;
      else
         pps_sr <= {pps_sr[PPS_SYNC_STAGES-1:0], pps_i};
   end

   assign pps_edge = pps_sr[PPS_SYNC_STAGES-1] & ~pps_sr[PPS_SYNC_STAGES];
   assign pps_load = pps_edge & pend_valid;

   // Value held for the next PPS
   always_ff @(posedge dsp_clk) begin
      if (time_load_i.load_at_pps)
         pend_time <= time_load_i.new_time;
   end

   //////////////////////////////
   // Counter, capture and sync flag
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         time_q      <= '0;
         time_pps_q  <= '0;
         pend_valid  <= 1'b0;
         good_sync_o <= 1'b0;
      end else begin
         if (pps_edge)
            time_pps_q <= time_q;   // Time at this PPS

         if (time_load_i.load_now) begin
            time_q <= time_load_i.new_time;
         end else if (pps_load) begin
            time_q      <= pend_time;
            good_sync_o <= 1'b1;    // Sticky until reset
         end else begin
            time_q <= time_q + 64'd1;
         end

         // Immediate load drops an armed PPS load
         if (time_load_i.load_at_pps)
            pend_valid <= 1'b1;
         else if (pps_edge || time_load_i.load_now)
            pend_valid <= 1'b0;
      end
   end

   assign vita_time_o     = time_q;
   assign vita_time_pps_o = time_pps_q;

endmodule

`default_nettype wire
